//--- design/gnn_defs.svh
`ifndef GNN_DEFS_SVH
`define GNN_DEFS_SVH

// vector size, one feature per column and one output per row.
`define GNN_DIM 4

// data widths.
`define GNN_FEAT_W 16
`define GNN_WGT_W 8
`define GNN_ACC_W 32
`define GNN_DBG_W 32

// address widths follow from the vector size.
`define GNN_FADDR_W $clog2(`GNN_DIM)
`define GNN_WADDR_W (2 * `GNN_FADDR_W)

// largest positive result after saturation.
`define GNN_SAT_MAX ((2 ** (`GNN_FEAT_W - 1)) - 1)

// number of weights in the bank.
`define GNN_WGT_NUM (`GNN_DIM * `GNN_DIM)

`endif

//--- design/gnn_pkg.sv
`default_nettype none

`include "gnn_defs.svh"

package gnn_pkg;

  typedef logic signed [`GNN_FEAT_W-1:0] feat_t;
  typedef logic signed [`GNN_WGT_W-1:0]  wgt_t;
  typedef logic signed [`GNN_ACC_W-1:0]  acc_t;

  typedef logic [`GNN_FADDR_W-1:0] faddr_t; // feature or row index.
  typedef logic [`GNN_WADDR_W-1:0] waddr_t; // {row, col}.

  typedef logic [`GNN_DBG_W-1:0] dbg_word_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MAC,
    ST_WRITE
  } eng_state_t;

endpackage

`default_nettype wire

//--- design/feat_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "gnn_defs.svh"

module feat_mem (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire logic                          feat_we_i,
  input  wire logic [`GNN_FADDR_W-1:0]       feat_addr_i,
  input  wire logic signed [`GNN_FEAT_W-1:0] feat_data_i,
  input  wire logic                          wgt_we_i,
  input  wire logic [`GNN_WADDR_W-1:0]       wgt_addr_i,
  input  wire logic signed [`GNN_WGT_W-1:0]  wgt_data_i,
  input  wire logic [`GNN_FADDR_W-1:0]       feat_idx_i,
  input  wire logic [`GNN_WADDR_W-1:0]       wgt_idx_i,
  output logic signed [`GNN_FEAT_W-1:0]      feat_o,
  output logic signed [`GNN_WGT_W-1:0]       wgt_o
);

  logic signed [`GNN_FEAT_W-1:0] feat_q [`GNN_DIM];
  logic signed [`GNN_WGT_W-1:0]  wgt_q  [`GNN_WGT_NUM];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `GNN_DIM; i++) begin
        feat_q[i] <= '0;
      end
    end else if (feat_we_i) begin
      feat_q[feat_addr_i] <= feat_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `GNN_WGT_NUM; i++) begin
        wgt_q[i] <= '0;
      end
    end else if (wgt_we_i) begin
      wgt_q[wgt_addr_i] <= wgt_data_i; // row-major.
    end
  end

  // read ports go straight into the multiplier.
  assign feat_o = feat_q[feat_idx_i];
  assign wgt_o  = wgt_q[wgt_idx_i];

endmodule

`default_nettype wire

//--- design/dmvm_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "gnn_defs.svh"

module dmvm_engine (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           start_i,
  input  wire gnn_pkg::feat_t feat_i,
  input  wire gnn_pkg::wgt_t  wgt_i,
  output gnn_pkg::faddr_t     feat_idx_o,
  output gnn_pkg::waddr_t     wgt_idx_o,
  output logic                h_wr_en_o,
  output gnn_pkg::faddr_t     h_wr_addr_o,
  output gnn_pkg::feat_t      h_wr_data_o,
  output logic                busy_o,
  output logic                done_o
);

  localparam gnn_pkg::faddr_t LAST_IDX = gnn_pkg::faddr_t'(`GNN_DIM - 1);

  gnn_pkg::eng_state_t state_q;
  gnn_pkg::faddr_t     row_q;
  gnn_pkg::faddr_t     col_q;
  gnn_pkg::acc_t       acc_q;
  gnn_pkg::acc_t       prod;
  gnn_pkg::feat_t      sat_data;
  logic                busy_q;
  logic                done_q;

  // signed operands, so the product is sign-extended to the accumulator.
  assign prod = feat_i * wgt_i;

  // relu then clip to the positive range of a feature word.
  always_comb begin
    if (acc_q < 0) begin
      sat_data = '0;
    end else if (acc_q > `GNN_SAT_MAX) begin
      sat_data = gnn_pkg::feat_t'(`GNN_SAT_MAX);
    end else begin
      sat_data = acc_q[`GNN_FEAT_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= gnn_pkg::ST_IDLE;
      row_q   <= '0;
      col_q   <= '0;
      acc_q   <= '0;
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (done_q) begin
        busy_q <= 1'b0; // busy drops one cycle after done.
      end
      case (state_q)
        gnn_pkg::ST_IDLE: begin
          if (start_i && !busy_q) begin
            state_q <= gnn_pkg::ST_MAC;
            busy_q  <= 1'b1;
            row_q   <= '0;
            col_q   <= '0;
            acc_q   <= '0;
          end
        end
        gnn_pkg::ST_MAC: begin
          acc_q <= acc_q + prod;
          col_q <= col_q + 1'b1; // wraps to column 0 for the next row.
          if (col_q == LAST_IDX) begin
            state_q <= gnn_pkg::ST_WRITE;
          end
        end
        gnn_pkg::ST_WRITE: begin
          acc_q <= '0;
          row_q <= row_q + 1'b1;
          if (row_q == LAST_IDX) begin
            state_q <= gnn_pkg::ST_IDLE;
            done_q  <= 1'b1;
          end else begin
            state_q <= gnn_pkg::ST_MAC;
          end
        end
        default: state_q <= gnn_pkg::ST_IDLE;
      endcase
    end
  end

  assign feat_idx_o  = col_q;
  assign wgt_idx_o   = {row_q, col_q};
  assign h_wr_en_o   = (state_q == gnn_pkg::ST_WRITE);
  assign h_wr_addr_o = row_q;
  assign h_wr_data_o = sat_data;
  assign busy_o      = busy_q;
  assign done_o      = done_q;

  // done marks the end of a run, back in idle with every row written.
  a_done_after_last_row : assert property (
    @(posedge clk) disable iff (!rst_n)
    done_o |-> busy_o && (state_q == gnn_pkg::ST_IDLE) && (row_q == '0)
  );

  // results are only written inside a run, from the write state.
  a_wr_in_write_state : assert property (
    @(posedge clk) disable iff (!rst_n)
    h_wr_en_o |-> (state_q == gnn_pkg::ST_WRITE) && busy_o && $past(busy_o)
  );

endmodule

`default_nettype wire

//--- design/h_data_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "gnn_defs.svh"

module h_data_mem (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            wr_en_i,
  input  wire gnn_pkg::faddr_t wr_addr_i,
  input  wire gnn_pkg::feat_t  wr_data_i,
  input  wire gnn_pkg::faddr_t rd_addr_i,
  output gnn_pkg::feat_t       rd_data_o
);

  gnn_pkg::feat_t mem_q [`GNN_DIM];
  gnn_pkg::feat_t rd_data_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `GNN_DIM; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // host read, one cycle of latency.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data_q <= '0;
    end else begin
      rd_data_q <= mem_q[rd_addr_i];
    end
  end

  assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

//--- design/debug_monitor.sv
`timescale 1ns/1ns
`default_nettype none

`include "gnn_defs.svh"

module debug_monitor (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            start_i,
  input  wire logic            done_i,
  input  wire logic            busy_i,
  input  wire logic            feat_we_i,
  input  wire gnn_pkg::faddr_t feat_addr_i,
  input  wire gnn_pkg::faddr_t feat_limit_i,
  input  wire logic            h_wr_en_i,
  input  wire gnn_pkg::faddr_t h_wr_addr_i,
  input  wire gnn_pkg::feat_t  h_wr_data_i,
  input  wire gnn_pkg::faddr_t watch_addr_i,
  output gnn_pkg::dbg_word_t   flags_o,
  output gnn_pkg::dbg_word_t   capture_o,
  output gnn_pkg::dbg_word_t   rows_o
);

  logic start_seen;
  logic start_seen_q;
  logic done_seen;
  logic done_seen_q;
  logic feat_wr;
  logic feat_wr_q;
  logic feat_lim;
  logic feat_lim_q;
  logic watch_hit;

  gnn_pkg::feat_t     capture;
  gnn_pkg::feat_t     capture_q;
  gnn_pkg::dbg_word_t rows;
  gnn_pkg::dbg_word_t rows_q;

  // set on the event, then held until reset.
  assign start_seen = start_i ? 1'b1 : start_seen_q;
  assign done_seen  = done_i ? 1'b1 : done_seen_q;
  assign feat_wr    = feat_we_i ? 1'b1 : feat_wr_q;
  assign feat_lim   = (feat_we_i && (feat_addr_i >= feat_limit_i)) ? 1'b1 : feat_lim_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_seen_q <= 1'b0;
      done_seen_q  <= 1'b0;
      feat_wr_q    <= 1'b0;
      feat_lim_q   <= 1'b0;
    end else begin
      start_seen_q <= start_seen;
      done_seen_q  <= done_seen;
      feat_wr_q    <= feat_wr;
      feat_lim_q   <= feat_lim;
    end
  end

  assign watch_hit = h_wr_en_i && (h_wr_addr_i == watch_addr_i);
  assign capture   = watch_hit ? h_wr_data_i : capture_q;
  assign rows      = h_wr_en_i ? (rows_q + 1'b1) : rows_q; // one per result row.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      capture_q <= '0;
      rows_q    <= '0;
    end else begin
      capture_q <= capture;
      rows_q    <= rows;
    end
  end

  // busy is passed through live.
  assign flags_o   = gnn_pkg::dbg_word_t'({busy_i, feat_lim_q, feat_wr_q,
                                           done_seen_q, start_seen_q});
  assign capture_o = gnn_pkg::dbg_word_t'(capture_q); // sign-extends.
  assign rows_o    = rows_q;

  // the engine must not write results outside a run.
  a_wr_only_when_busy : assert property (
    @(posedge clk) disable iff (!rst_n)
    h_wr_en_i |-> busy_i
  );

endmodule

`default_nettype wire

//--- design/gnn_layer_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "gnn_defs.svh"

module gnn_layer_top (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            feat_we_i,
  input  wire gnn_pkg::faddr_t feat_addr_i,
  input  wire gnn_pkg::feat_t  feat_data_i,
  input  wire logic            wgt_we_i,
  input  wire gnn_pkg::waddr_t wgt_addr_i,
  input  wire gnn_pkg::wgt_t   wgt_data_i,
  input  wire logic            start_i,
  input  wire gnn_pkg::faddr_t watch_addr_i,
  input  wire gnn_pkg::faddr_t feat_limit_i,
  input  wire gnn_pkg::faddr_t h_rd_addr_i,
  output logic                 busy_o,
  output logic                 done_o,
  output gnn_pkg::feat_t       h_rd_data_o,
  output gnn_pkg::dbg_word_t   dbg_flags_o,
  output gnn_pkg::dbg_word_t   dbg_capture_o,
  output gnn_pkg::dbg_word_t   dbg_rows_o
);

  gnn_pkg::faddr_t feat_idx;
  gnn_pkg::waddr_t wgt_idx;
  gnn_pkg::feat_t  feat_rd;
  gnn_pkg::wgt_t   wgt_rd;
  logic            h_wr_en;
  gnn_pkg::faddr_t h_wr_addr;
  gnn_pkg::feat_t  h_wr_data;

  feat_mem i_feat_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .feat_we_i   (feat_we_i),
    .feat_addr_i (feat_addr_i),
    .feat_data_i (feat_data_i),
    .wgt_we_i    (wgt_we_i),
    .wgt_addr_i  (wgt_addr_i),
    .wgt_data_i  (wgt_data_i),
    .feat_idx_i  (feat_idx),
    .wgt_idx_i   (wgt_idx),
    .feat_o      (feat_rd),
    .wgt_o       (wgt_rd)
  );

  dmvm_engine i_dmvm_engine (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .feat_i      (feat_rd),
    .wgt_i       (wgt_rd),
    .feat_idx_o  (feat_idx),
    .wgt_idx_o   (wgt_idx),
    .h_wr_en_o   (h_wr_en),
    .h_wr_addr_o (h_wr_addr),
    .h_wr_data_o (h_wr_data),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  h_data_mem i_h_data_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en_i   (h_wr_en),
    .wr_addr_i (h_wr_addr),
    .wr_data_i (h_wr_data),
    .rd_addr_i (h_rd_addr_i),
    .rd_data_o (h_rd_data_o)
  );

  debug_monitor i_debug_monitor (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .done_i       (done_o),
    .busy_i       (busy_o),
    .feat_we_i    (feat_we_i),
    .feat_addr_i  (feat_addr_i),
    .feat_limit_i (feat_limit_i),
    .h_wr_en_i    (h_wr_en),
    .h_wr_addr_i  (h_wr_addr),
    .h_wr_data_i  (h_wr_data),
    .watch_addr_i (watch_addr_i),
    .flags_o      (dbg_flags_o),
    .capture_o    (dbg_capture_o),
    .rows_o       (dbg_rows_o)
  );

endmodule

`default_nettype wire

//--- verification/gnn_layer_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "gnn_defs.svh"

module gnn_layer_tb;

  localparam int RST_CYCLES  = 5;
  localparam int NUM_CASES   = 6;
  localparam int CASE_CYCLES = 60;
  localparam int MAX_CYCLES  = RST_CYCLES + NUM_CASES * CASE_CYCLES + 135; // 500 cycles.
  localparam int DONE_LAT    = 21;
  localparam int DONE_WAIT   = 40;

  logic clk, rst_n, feat_we_i, wgt_we_i, start_i, busy_o, done_o;
  gnn_pkg::faddr_t    feat_addr_i, watch_addr_i, feat_limit_i, h_rd_addr_i;
  gnn_pkg::feat_t     feat_data_i, h_rd_data_o;
  gnn_pkg::waddr_t    wgt_addr_i;
  gnn_pkg::wgt_t      wgt_data_i;
  gnn_pkg::dbg_word_t dbg_flags_o, dbg_capture_o, dbg_rows_o;

  gnn_pkg::feat_t  case_feat [`GNN_DIM];
  gnn_pkg::wgt_t   case_wgt [`GNN_WGT_NUM];
  gnn_pkg::faddr_t case_watch, case_limit;
  int    err_count = 0, pass_count = 0, fail_count = 0, run_count = 0, cycle_count = 0;
  logic  lim_seen = 1'b0; // expected flag bit 3.
  string test_name;

  gnn_layer_top i_dut (
    .clk (clk), .rst_n (rst_n),
    .feat_we_i (feat_we_i), .feat_addr_i (feat_addr_i), .feat_data_i (feat_data_i),
    .wgt_we_i (wgt_we_i), .wgt_addr_i (wgt_addr_i), .wgt_data_i (wgt_data_i),
    .start_i (start_i), .watch_addr_i (watch_addr_i), .feat_limit_i (feat_limit_i),
    .h_rd_addr_i (h_rd_addr_i), .busy_o (busy_o), .done_o (done_o),
    .h_rd_data_o (h_rd_data_o), .dbg_flags_o (dbg_flags_o),
    .dbg_capture_o (dbg_capture_o), .dbg_rows_o (dbg_rows_o)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
      err_count++;
    end
  endtask

  // row dot product, then relu and clip to 7fff.
  function automatic gnn_pkg::feat_t expected_row(input int row);
    longint sum;
    sum = 0;
    for (int c = 0; c < `GNN_DIM; c++) begin
      sum += longint'(case_feat[c]) * longint'(case_wgt[row * `GNN_DIM + c]);
    end
    if (sum < 0) begin
      return 16'h0000;
    end else if (sum > 64'sh7fff) begin
      return 16'h7fff;
    end
    return gnn_pkg::feat_t'(sum);
  endfunction

  task automatic report_test(input int errs_before);
    if (err_count == errs_before) begin
      pass_count++;
      $display("%s: ok", test_name);
    end else begin
      fail_count++;
      $display("%s: %0d check(s) failed", test_name, err_count - errs_before);
    end
  endtask

  task automatic run_case(input int num);
    int             errs_before;
    int             lat;
    logic           got_done;
    gnn_pkg::feat_t cap;
    errs_before = err_count;
    test_name   = $sformatf("case%0d", num);
    @(posedge clk);
    watch_addr_i <= case_watch;
    feat_limit_i <= case_limit;
    for (int i = 0; i < `GNN_DIM; i++) begin
      @(posedge clk);
      feat_we_i   <= 1'b1;
      feat_addr_i <= gnn_pkg::faddr_t'(i);
      feat_data_i <= case_feat[i];
      @(posedge clk);
      feat_we_i <= 1'b0;
      lim_seen  = lim_seen | (gnn_pkg::faddr_t'(i) >= case_limit);
      @(negedge clk);
      check_value("feature write flags", {30'b0, lim_seen, 1'b1}, {30'b0, dbg_flags_o[3:2]});
    end
    for (int i = 0; i < `GNN_WGT_NUM; i++) begin
      @(posedge clk);
      wgt_we_i   <= 1'b1;
      wgt_addr_i <= gnn_pkg::waddr_t'(i); // row-major.
      wgt_data_i <= case_wgt[i];
    end
    @(posedge clk);
    wgt_we_i <= 1'b0;
    @(negedge clk);
    check_value("busy before start", 32'd0, {31'b0, busy_o});
    @(posedge clk);
    start_i  <= 1'b1;
    lat      = 0;
    got_done = 1'b0;
    while (!got_done && lat < DONE_WAIT) begin
      @(posedge clk);
      lat++;
      start_i <= (num % 2 == 0) && (lat == 8); // even cases restart mid-run.
      @(negedge clk);
      check_value("busy during run", 32'd3, {30'b0, dbg_flags_o[4], busy_o});
      got_done = done_o;
    end
    if (!got_done) begin
      $display("%s: done_o did not arrive within %0d cycles of start_i", test_name, DONE_WAIT);
      err_count++;
    end else begin
      run_count++;
      check_value("done latency", DONE_LAT, lat);
    end
    @(posedge clk);
    @(negedge clk);
    check_value("busy after done", 32'd0, {31'b0, busy_o});
    for (int r = 0; r < `GNN_DIM; r++) begin
      @(posedge clk);
      h_rd_addr_i <= gnn_pkg::faddr_t'(r);
      @(posedge clk);
      @(negedge clk);
      check_value($sformatf("result row %0d", r), {16'b0, expected_row(r)}, {16'b0, h_rd_data_o});
    end
    cap = expected_row(case_watch);
    check_value("debug capture", {{16{cap[15]}}, cap}, dbg_capture_o);
    check_value("debug rows", run_count * `GNN_DIM, dbg_rows_o);
    check_value("debug flags", {27'b0, 1'b0, lim_seen, 3'b111}, dbg_flags_o);
    report_test(errs_before);
  endtask

  initial begin
    integer fd;
    string  line;
    int     n;
    int     num;
    clk = 1'b0;
    rst_n = 1'b0;
    {feat_we_i, wgt_we_i, start_i} = '0;
    {feat_addr_i, watch_addr_i, feat_limit_i, h_rd_addr_i} = '0;
    {feat_data_i, wgt_addr_i, wgt_data_i} = '0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    test_name = "reset";
    check_value("busy and done", 32'd0, {30'b0, busy_o, done_o});
    check_value("debug flags", 32'd0, dbg_flags_o);
    check_value("debug capture", 32'd0, dbg_capture_o);
    check_value("debug rows", 32'd0, dbg_rows_o);
    report_test(0);
    num = 0;
    fd  = $fopen("verification/gnn_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open verification/gnn_cases.txt");
      err_count++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      case_feat[0], case_feat[1], case_feat[2], case_feat[3],
                      case_wgt[0], case_wgt[1], case_wgt[2], case_wgt[3], case_wgt[4],
                      case_wgt[5], case_wgt[6], case_wgt[7], case_wgt[8], case_wgt[9],
                      case_wgt[10], case_wgt[11], case_wgt[12], case_wgt[13], case_wgt[14],
                      case_wgt[15], case_watch, case_limit);
          if (n == 22) begin
            num++;
            run_case(num);
          end else if (n > 0) begin
            $display("malformed line in the case file: %s", line);
            err_count++;
          end
        end
      end
      $fclose(fd);
    end
    if (num != NUM_CASES) begin
      $display("the case file gave %0d cases instead of %0d", num, NUM_CASES);
      err_count++;
    end
    $display("tests: %0d passed, %0d failed", pass_count, fail_count);
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/gnn_cases.txt
# columns: feat0 feat1 feat2 feat3 (16-bit hex), then 16 weights w[row*4+col] (8-bit hex),
# then watch address and feature limit (2-bit hex).
# plain positive
0001 0002 0003 0004 01 02 03 04 05 06 07 08 01 01 01 01 02 00 00 01 1 3
# all-negative
fff0 ffe0 ffd0 ffc0 01 02 03 04 04 03 02 01 7f 7f 7f 7f 01 01 01 01 2 0
# saturating
1000 1000 1000 1000 10 10 10 10 7f 10 00 00 20 20 20 20 01 00 00 00 3 1
# mixed
0100 ff00 0080 fff6 01 01 01 01 02 ff 00 00 ff 01 00 00 00 00 7f 80 0 2
# zero weights
1234 5678 9abc def0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 3
# maximum values
7fff 7fff 8000 8000 7f 7f 80 80 7f 7f 7f 7f 00 00 80 80 80 80 00 00 3 0

//--- flist.f
+incdir+design
design/gnn_pkg.sv
design/feat_mem.sv
design/dmvm_engine.sv
design/h_data_mem.sv
design/debug_monitor.sv
design/gnn_layer_top.sv
verification/gnn_layer_tb.sv
